//--- bender.yml
package:
  name: window_feeder

sources:
  - source/window_feeder_pkg.sv
  - source/dp_ram.sv
  - source/window_sequencer.sv
  - source/scan_counter.sv
  - source/row_window.sv
  - source/window_feeder.sv
  - target: test
    files:
      - dv/window_feeder_checker.sv
      - dv/tb_window_feeder.sv

//--- dv/tb_window_feeder.sv
`timescale 1ns/1ps

module tb_window_feeder;
    import window_feeder_pkg::*;

    logic              clk;
    logic              rstn;
    logic              ld_en;
    logic [FM_AW-1:0]  ld_addr;
    logic [DATA_W-1:0] ld_data;
    logic              start;
    logic [SIZE_W-1:0] cfg_width;
    logic [SIZE_W-1:0] cfg_height;
    logic [CHN_W-1:0]  cfg_channel;
    logic              busy;
    logic              done;
    logic              win_valid;
    logic [DATA_W-1:0] win_above;
    logic [DATA_W-1:0] win_cur;
    logic [DATA_W-1:0] win_below;

    // run bookkeeping
    logic [31:0] lfsr_state;
    int          tb_errors;
    int          tests_run;
    int          total_beats;
    bit          timed_out;

    window_feeder u_window_feeder (
        .clk         (clk),
        .rstn        (rstn),
        .ld_en       (ld_en),
        .ld_addr     (ld_addr),
        .ld_data     (ld_data),
        .start       (start),
        .cfg_width   (cfg_width),
        .cfg_height  (cfg_height),
        .cfg_channel (cfg_channel),
        .busy        (busy),
        .done        (done),
        .win_valid   (win_valid),
        .win_above   (win_above),
        .win_cur     (win_cur),
        .win_below   (win_below)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------
    // stimulus helpers
    // --------------------
    // galois step, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per data bit
    task automatic draw_word(output logic [DATA_W-1:0] w);
        w = '0;
        for (int b = 0; b < DATA_W; b++) begin
            w = {w[DATA_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic load_map(input int n_words);
        logic [DATA_W-1:0] w;
        for (int a = 0; a < n_words; a++) begin
            draw_word(w);
            ld_en   = 1'b1;
            ld_addr = FM_AW'(a);
            ld_data = w;
            @(negedge clk);
        end
        ld_en = 1'b0;
    endtask

    function automatic int error_total();
        return tb_errors + u_window_feeder.u_checker.err_cnt;
    endfunction

    task automatic report_test(input string name, input int beats, input int err_before);
        int errs;
        errs = error_total() - err_before;
        tests_run++;
        $display("%s: %0d beats, %0d errors%s", name, beats, errs,
                 timed_out ? ", timed out" : "");
    endtask

    // --------------------
    // test bodies
    // --------------------
    task automatic idle_cycles(input string name, input int n);
        int err_before;
        int active;
        err_before = error_total();
        active = 0;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (busy || done || win_valid) begin
                active++;
            end
        end
        if (active != 0) begin
            $display("%0t: feeder active on %0d idle cycles in %s", $time, active, name);
            tb_errors++;
        end
        report_test(name, 0, err_before);
    endtask

    // one frame, optionally with a second start while busy
    task automatic run_frame(input string name, input int w, input int h, input int c,
                             input bit extra_start);
        int beats;
        int dones;
        int cycles;
        int limit;
        int err_before;
        if (!timed_out) begin
            beats      = 0;
            dones      = 0;
            cycles     = 0;
            limit      = w * c * (h + 1) + 40;
            err_before = error_total();
            start       = 1'b1;
            cfg_width   = SIZE_W'(w);
            cfg_height  = SIZE_W'(h);
            cfg_channel = CHN_W'(c);
            @(negedge clk);
            start = 1'b0;
            if (!busy) begin
                $display("%0t: busy did not rise after start in %s", $time, name);
                tb_errors++;
            end
            while (dones == 0 && cycles < limit) begin
                start = extra_start && (cycles == 3);
                if (start) begin
                    cfg_width   = 6'd2;
                    cfg_height  = 6'd2;
                    cfg_channel = 4'd1;
                end
                @(negedge clk);
                cycles++;
                if (win_valid) begin
                    beats++;
                end
                if (done) begin
                    dones++;
                end
            end
            start = 1'b0;
            if (dones == 0) begin
                $display("%0t: timeout, no done within %0d cycles in %s", $time, limit, name);
                timed_out = 1'b1;
            end else if (beats != w * h * c) begin
                $display("Mismatch at %0t: win_valid beat count got %0d expected %0d",
                         $time, beats, w * h * c);
                tb_errors++;
            end
            // the ignored start must not open another frame
            if (extra_start && !timed_out) begin
                for (int i = 0; i < 16; i++) begin
                    @(negedge clk);
                    if (busy || done) begin
                        dones++;
                    end
                end
                if (dones != 1) begin
                    $display("%0t: start while busy led to a second frame in %s", $time, name);
                    tb_errors++;
                end
            end
            total_beats += beats;
            report_test(name, beats, err_before);
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        rstn        = 1'b0;
        ld_en       = 1'b0;
        ld_addr     = '0;
        ld_data     = '0;
        start       = 1'b0;
        cfg_width   = '0;
        cfg_height  = '0;
        cfg_channel = '0;
        lfsr_state  = 32'h4f54f0e5;
        tb_errors   = 0;
        tests_run   = 0;
        total_beats = 0;
        timed_out   = 1'b0;

        repeat (16) @(negedge clk);
        rstn = 1'b1;

        idle_cycles("test 1 idle after reset", 20);
        load_map(256);
        run_frame("test 2 width 4 height 3 channels 1", 4, 3, 1, 1'b0);
        run_frame("test 3 width 5 height 4 channels 3", 5, 4, 3, 1'b0);
        run_frame("test 4 width 6 height 1 channels 2", 6, 1, 2, 1'b0);
        run_frame("test 5 start while busy", 4, 3, 2, 1'b1);
        // fresh data, then two frames with no gap
        load_map(256);
        run_frame("test 6a back to back width 3 height 5", 3, 5, 2, 1'b0);
        run_frame("test 6b back to back width 7 height 2", 7, 2, 1, 1'b0);

        $display("tests %0d, beats %0d, testbench errors %0d, assertion errors %0d, timeout %0d",
                 tests_run, total_beats, tb_errors, u_window_feeder.u_checker.err_cnt,
                 timed_out);
        if (error_total() == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- dv/window_feeder_checker.sv
`timescale 1ns/1ps

module window_feeder_checker (
    input logic                                 clk,
    input logic                                 rstn,
    input logic                                 ld_en,
    input logic [window_feeder_pkg::FM_AW-1:0]  ld_addr,
    input logic [window_feeder_pkg::DATA_W-1:0] ld_data,
    input logic                                 start,
    input logic [window_feeder_pkg::SIZE_W-1:0] cfg_width,
    input logic [window_feeder_pkg::SIZE_W-1:0] cfg_height,
    input logic [window_feeder_pkg::CHN_W-1:0]  cfg_channel,
    input logic                                 busy,
    input logic                                 done,
    input logic                                 win_valid,
    input logic [window_feeder_pkg::DATA_W-1:0] win_above,
    input logic [window_feeder_pkg::DATA_W-1:0] win_cur,
    input logic [window_feeder_pkg::DATA_W-1:0] win_below
);
    import window_feeder_pkg::*;

    // shadow of the map RAM
    logic [DATA_W-1:0] shadow [1 << FM_AW];

    // frame size taken at the accepted start
    int frame_w;
    int frame_h;
    int frame_c;
    int stride;
    int total;

    // position of the next expected beat
    int row;
    int col;
    int chn;
    int idx;
    int beat_cnt;
    bit seen_start;

    logic [DATA_W-1:0] exp_above;
    logic [DATA_W-1:0] exp_cur;
    logic [DATA_W-1:0] exp_below;

    // one count per assertion, summed for the testbench
    int err_words = 0;
    int err_count = 0;
    int err_done  = 0;
    int err_busy  = 0;
    int err_quiet = 0;
    int err_cnt;

    assign err_cnt = err_words + err_count + err_done + err_busy + err_quiet;

    // --------------------
    // shadow model
    // --------------------
    always_ff @(posedge clk) begin
        if (ld_en) begin
            shadow[ld_addr] <= ld_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            seen_start <= 1'b0;
            frame_w    <= 1;
            frame_h    <= 1;
            frame_c    <= 1;
            row        <= 0;
            col        <= 0;
            chn        <= 0;
            beat_cnt   <= 0;
        end else if (start && !busy) begin
            seen_start <= 1'b1;
            frame_w    <= int'(cfg_width);
            frame_h    <= int'(cfg_height);
            frame_c    <= int'(cfg_channel);
            row        <= 0;
            col        <= 0;
            chn        <= 0;
            beat_cnt   <= 0;
        end else if (win_valid) begin
            beat_cnt <= beat_cnt + 1;
            // channel innermost, then column, then row
            if (chn == frame_c - 1) begin
                chn <= 0;
                if (col == frame_w - 1) begin
                    col <= 0;
                    row <= row + 1;
                end else begin
                    col <= col + 1;
                end
            end else begin
                chn <= chn + 1;
            end
        end
    end

    assign stride = frame_w * frame_c;
    assign total  = stride * frame_h;
    assign idx    = row * stride + col * frame_c + chn;

    // edge rows read as zero
    always_comb begin
        exp_cur   = shadow[FM_AW'(idx)];
        exp_above = (row == 0) ? '0 : shadow[FM_AW'(idx - stride)];
        exp_below = (row == frame_h - 1) ? '0 : shadow[FM_AW'(idx + stride)];
    end

    // --------------------
    // assertions
    // --------------------
    a_words: assert property (@(posedge clk) disable iff (!rstn)
        win_valid |-> (win_above == exp_above) && (win_cur == exp_cur)
                      && (win_below == exp_below))
    else begin
        $error("Mismatch at %0t: win_above/win_cur/win_below got %h %h %h expected %h %h %h",
               $time, $sampled(win_above), $sampled(win_cur), $sampled(win_below),
               $sampled(exp_above), $sampled(exp_cur), $sampled(exp_below));
        err_words++;
    end

    // all beats of the frame seen by done
    a_count: assert property (@(posedge clk) disable iff (!rstn)
        done |-> (beat_cnt == total))
    else begin
        $error("Mismatch at %0t: beat count at done got %0d expected %0d",
               $time, $sampled(beat_cnt), $sampled(total));
        err_count++;
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
        done |=> !done)
    else begin
        $error("done stayed high for more than one cycle at %0t", $time);
        err_done++;
    end

    a_valid_busy: assert property (@(posedge clk) disable iff (!rstn)
        win_valid |-> busy)
    else begin
        $error("win_valid high while the feeder was not busy at %0t", $time);
        err_busy++;
    end

    // nothing moves between reset and the first start
    a_quiet: assert property (@(posedge clk) disable iff (!rstn)
        !seen_start |-> !busy && !done && !win_valid && (win_above == '0)
                        && (win_cur == '0) && (win_below == '0))
    else begin
        $error("outputs active before any start at %0t", $time);
        err_quiet++;
    end

endmodule

bind window_feeder window_feeder_checker u_checker (.*);

//--- files.f
source/window_feeder_pkg.sv
source/dp_ram.sv
source/window_sequencer.sv
source/scan_counter.sv
source/row_window.sv
source/window_feeder.sv
dv/window_feeder_checker.sv
dv/tb_window_feeder.sv

//--- source/dp_ram.sv
`timescale 1ns/1ps

module dp_ram #(
    parameter int DEPTH = 256,
    parameter int AW    = 8,
    parameter int DW    = 32
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  logic [DW-1:0] wdata,
    input  logic          re,
    input  logic [AW-1:0] raddr,
    output logic [DW-1:0] rdata
);

    // storage array
    logic [DW-1:0] mem [DEPTH];

    // --------------------
    // write port
    // --------------------
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // --------------------
    // read port, one cycle latency
    // --------------------
    // a same-address write on the same edge is passed straight through,
    // so a row slot read right behind its own fill sees the new word
    always_ff @(posedge clk) begin
        if (re) begin
            if (we && (waddr == raddr)) begin
                rdata <= wdata;
            end else begin
                rdata <= mem[raddr];
            end
        end
    end

endmodule

//--- source/row_window.sv
`timescale 1ns/1ps

module row_window (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 pos_valid,
    input  logic                                 pos_prefill,
    input  logic [window_feeder_pkg::ROW_AW-1:0] row_offset,
    input  logic                                 first_row,
    input  logic                                 last_row,
    input  logic                                 pos_row_end,
    input  logic [window_feeder_pkg::DATA_W-1:0] fm_rdata,
    output logic                                 win_valid,
    output logic [window_feeder_pkg::DATA_W-1:0] win_above,
    output logic [window_feeder_pkg::DATA_W-1:0] win_cur,
    output logic [window_feeder_pkg::DATA_W-1:0] win_below
);
    import window_feeder_pkg::*;

    // stage 2 controls, aligned with fm_rdata
    logic              vld_d;
    logic              prefill_d;
    logic [ROW_AW-1:0] offset_d;
    logic              first_d;
    logic              last_d;
    logic              row_end_d;

    // slot roles, above and below follow cur
    logic [1:0] cur_sel;
    logic [1:0] below_sel;
    logic [1:0] above_sel;

    logic [2:0]        slot_we;
    logic              slot_re;
    logic [DATA_W-1:0] slot_rdata [3];

    logic [DATA_W-1:0] above_mux;
    logic [DATA_W-1:0] below_mux;

    // --------------------
    // control delay
    // --------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_d     <= 1'b0;
            prefill_d <= 1'b0;
            first_d   <= 1'b0;
            last_d    <= 1'b0;
            row_end_d <= 1'b0;
        end else begin
            vld_d     <= pos_valid;
            prefill_d <= pos_prefill;
            first_d   <= first_row;
            last_d    <= last_row;
            row_end_d <= pos_row_end;
        end
    end

    // slot write address
    always_ff @(posedge clk) begin
        offset_d <= row_offset;
    end

    // --------------------
    // slot roles
    // --------------------
    assign below_sel = (cur_sel == 2'd2) ? 2'd0 : cur_sel + 2'd1;
    assign above_sel = (cur_sel == 2'd0) ? 2'd2 : cur_sel - 2'd1;

    // below slot becomes current at each streamed row end
    // roles stay self-consistent across frames since prefill fills cur
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cur_sel <= 2'd0;
        end else if (vld_d && !prefill_d && row_end_d) begin
            cur_sel <= below_sel;
        end
    end

    // --------------------
    // slot RAMs
    // --------------------
    // reads only while streaming, same offset in all slots
    assign slot_re = pos_valid && !pos_prefill;

    for (genvar i = 0; i < 3; i++) begin : g_slot
        // prefill fills cur, streaming fills below
        assign slot_we[i] = vld_d && (prefill_d ? (cur_sel == 2'(i))
                                                : (below_sel == 2'(i)) && !last_d);

        dp_ram #(
            .DEPTH (1 << ROW_AW),
            .AW    (ROW_AW),
            .DW    (DATA_W)
        ) u_slot (
            .clk   (clk),
            .we    (slot_we[i]),
            .waddr (offset_d),
            .wdata (fm_rdata),
            .re    (slot_re),
            .raddr (row_offset),
            .rdata (slot_rdata[i])
        );
    end

    // --------------------
    // edge zeroing and output regs
    // --------------------
    assign above_mux = first_d ? '0 : slot_rdata[above_sel];
    // below comes straight from the map read
    assign below_mux = last_d ? '0 : fm_rdata;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            win_valid <= 1'b0;
            win_above <= '0;
            win_cur   <= '0;
            win_below <= '0;
        end else if (vld_d && !prefill_d) begin
            win_valid <= 1'b1;
            win_above <= above_mux;
            win_cur   <= slot_rdata[cur_sel];
            win_below <= below_mux;
        end else begin
            // quiet between beats
            win_valid <= 1'b0;
            win_above <= '0;
            win_cur   <= '0;
            win_below <= '0;
        end
    end

endmodule

//--- source/scan_counter.sv
`timescale 1ns/1ps

module scan_counter (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic [window_feeder_pkg::SIZE_W-1:0] cfg_width,
    input  logic [window_feeder_pkg::SIZE_W-1:0] cfg_height,
    input  logic [window_feeder_pkg::CHN_W-1:0]  cfg_channel,
    input  logic                                 cnt_clear,
    input  logic                                 cnt_step,
    input  logic                                 prefill,
    output logic                                 row_end,
    output logic                                 frame_end,
    output logic                                 pos_valid,
    output logic                                 pos_prefill,
    output logic [window_feeder_pkg::ROW_AW-1:0] row_offset,
    output logic                                 first_row,
    output logic                                 last_row,
    output logic                                 pos_row_end,
    output logic                                 fm_rd_en,
    output logic [window_feeder_pkg::FM_AW-1:0]  fm_rd_addr
);
    import window_feeder_pkg::*;

    // latched frame config
    logic [SIZE_W-1:0]   frame_width;
    logic [SIZE_W-1:0]   frame_height;
    logic [CHN_W-1:0]    frame_chn;
    logic [STRIDE_W-1:0] stride;

    // scan position, channel innermost
    logic [CHN_W-1:0]  chn;
    logic [SIZE_W-1:0] col;
    logic [SIZE_W-1:0] row;
    logic [ROW_AW-1:0] offset;
    logic [FM_AW-1:0]  row_base;

    logic last_chn;
    logic last_col;
    logic on_last_row;

    // --------------------
    // config, stride computed once per frame
    // --------------------
    always_ff @(posedge clk) begin
        if (cnt_clear) begin
            frame_width  <= cfg_width;
            frame_height <= cfg_height;
            frame_chn    <= cfg_channel;
            stride       <= STRIDE_W'(cfg_width) * STRIDE_W'(cfg_channel);
        end
    end

    // position flags
    assign last_chn    = (chn == frame_chn - 1'b1);
    assign last_col    = (col == frame_width - 1'b1);
    assign on_last_row = (row == frame_height - 1'b1);
    assign row_end     = last_chn && last_col;
    assign frame_end   = row_end && on_last_row;

    // --------------------
    // position counters
    // --------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            chn      <= '0;
            col      <= '0;
            row      <= '0;
            offset   <= '0;
            row_base <= '0;
        end else if (cnt_clear) begin
            chn      <= '0;
            col      <= '0;
            row      <= '0;
            offset   <= '0;
            row_base <= '0;
        end else if (cnt_step) begin
            if (row_end) begin
                chn    <= '0;
                col    <= '0;
                offset <= '0;
                // prefill wraps back onto row 0
                if (!prefill) begin
                    row      <= row + 1'b1;
                    row_base <= row_base + FM_AW'(stride);
                end
            end else if (last_chn) begin
                chn    <= '0;
                col    <= col + 1'b1;
                offset <= offset + 1'b1;
            end else begin
                chn    <= chn + 1'b1;
                offset <= offset + 1'b1;
            end
        end
    end

    // --------------------
    // stage 1 outputs
    // --------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pos_valid   <= 1'b0;
            pos_prefill <= 1'b0;
            first_row   <= 1'b0;
            last_row    <= 1'b0;
            pos_row_end <= 1'b0;
            fm_rd_en    <= 1'b0;
        end else begin
            pos_valid   <= cnt_step;
            pos_prefill <= prefill;
            first_row   <= (row == '0);
            last_row    <= on_last_row;
            pos_row_end <= row_end;
            // nothing below the last row
            fm_rd_en    <= cnt_step && (prefill || !on_last_row);
        end
    end

    // offset and map address, below row while streaming
    always_ff @(posedge clk) begin
        row_offset <= offset;
        if (prefill) begin
            fm_rd_addr <= FM_AW'(offset);
        end else begin
            fm_rd_addr <= row_base + FM_AW'(stride) + FM_AW'(offset);
        end
    end

endmodule

//--- source/window_feeder.sv
`timescale 1ns/1ps

module window_feeder (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 ld_en,
    input  logic [window_feeder_pkg::FM_AW-1:0]  ld_addr,
    input  logic [window_feeder_pkg::DATA_W-1:0] ld_data,
    input  logic                                 start,
    input  logic [window_feeder_pkg::SIZE_W-1:0] cfg_width,
    input  logic [window_feeder_pkg::SIZE_W-1:0] cfg_height,
    input  logic [window_feeder_pkg::CHN_W-1:0]  cfg_channel,
    output logic                                 busy,
    output logic                                 done,
    output logic                                 win_valid,
    output logic [window_feeder_pkg::DATA_W-1:0] win_above,
    output logic [window_feeder_pkg::DATA_W-1:0] win_cur,
    output logic [window_feeder_pkg::DATA_W-1:0] win_below
);
    import window_feeder_pkg::*;

    // sequencer and counter handshake
    logic cnt_clear;
    logic cnt_step;
    logic prefill;
    logic row_end;
    logic frame_end;

    // stage 1 position
    logic              pos_valid;
    logic              pos_prefill;
    logic [ROW_AW-1:0] row_offset;
    logic              first_row;
    logic              last_row;
    logic              pos_row_end;

    // map read port
    logic              fm_rd_en;
    logic [FM_AW-1:0]  fm_rd_addr;
    logic [DATA_W-1:0] fm_rdata;

    // --------------------
    // map RAM, host writes, feeder reads
    // --------------------
    dp_ram #(
        .DEPTH (1 << FM_AW),
        .AW    (FM_AW),
        .DW    (DATA_W)
    ) u_fm_ram (
        .clk   (clk),
        .we    (ld_en),
        .waddr (ld_addr),
        .wdata (ld_data),
        .re    (fm_rd_en),
        .raddr (fm_rd_addr),
        .rdata (fm_rdata)
    );

    // --------------------
    // control
    // --------------------
    window_sequencer u_sequencer (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .row_end   (row_end),
        .frame_end (frame_end),
        .cnt_clear (cnt_clear),
        .cnt_step  (cnt_step),
        .prefill   (prefill),
        .busy      (busy),
        .done      (done)
    );

    scan_counter u_scan_counter (
        .clk         (clk),
        .rstn        (rstn),
        .cfg_width   (cfg_width),
        .cfg_height  (cfg_height),
        .cfg_channel (cfg_channel),
        .cnt_clear   (cnt_clear),
        .cnt_step    (cnt_step),
        .prefill     (prefill),
        .row_end     (row_end),
        .frame_end   (frame_end),
        .pos_valid   (pos_valid),
        .pos_prefill (pos_prefill),
        .row_offset  (row_offset),
        .first_row   (first_row),
        .last_row    (last_row),
        .pos_row_end (pos_row_end),
        .fm_rd_en    (fm_rd_en),
        .fm_rd_addr  (fm_rd_addr)
    );

    // --------------------
    // row slots and output beat
    // --------------------
    row_window u_row_window (
        .clk         (clk),
        .rstn        (rstn),
        .pos_valid   (pos_valid),
        .pos_prefill (pos_prefill),
        .row_offset  (row_offset),
        .first_row   (first_row),
        .last_row    (last_row),
        .pos_row_end (pos_row_end),
        .fm_rdata    (fm_rdata),
        .win_valid   (win_valid),
        .win_above   (win_above),
        .win_cur     (win_cur),
        .win_below   (win_below)
    );

endmodule

//--- source/window_feeder_pkg.sv
package window_feeder_pkg;

    // --------------------
    // data and config field widths
    // --------------------

    // one feature word
    localparam int DATA_W = 32;

    // width or height field
    localparam int SIZE_W = 6;

    // tiled channel count field
    localparam int CHN_W = 4;

    // row stride, width times channels
    localparam int STRIDE_W = SIZE_W + CHN_W;

    // --------------------
    // memory sizes
    // --------------------

    // map RAM, 4096 words
    localparam int FM_AW = 12;

    // one row slot, stride limited to 256 words
    localparam int ROW_AW = 8;

    // --------------------
    // pipeline timing
    // --------------------

    // counter step to output beat
    localparam int PIPE_LAT = 3;
    localparam int DRAIN_W  = $clog2(PIPE_LAT);

    // sequencer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREFILL,
        ST_STREAM,
        ST_DRAIN
    } seq_state_t;

endpackage

//--- source/window_sequencer.sv
`timescale 1ns/1ps

module window_sequencer (
    input  logic clk,
    input  logic rstn,
    input  logic start,
    input  logic row_end,
    input  logic frame_end,
    output logic cnt_clear,
    output logic cnt_step,
    output logic prefill,
    output logic busy,
    output logic done
);
    import window_feeder_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;

    // drain wait counter
    logic [DRAIN_W-1:0] drain_cnt;
    logic               drain_last;

    // last beat leaves the pipe on this drain cycle
    assign drain_last = (drain_cnt == DRAIN_W'(PIPE_LAT - 1));

    // --------------------
    // next state
    // --------------------
    always_comb begin
        state_nxt = state;
        case (state)
            // start only seen here, ignored while busy
            ST_IDLE: begin
                if (start) begin
                    state_nxt = ST_PREFILL;
                end
            end
            // single row walk, ends on last column and channel
            ST_PREFILL: begin
                if (row_end) begin
                    state_nxt = ST_STREAM;
                end
            end
            // full raster walk
            ST_STREAM: begin
                if (frame_end) begin
                    state_nxt = ST_DRAIN;
                end
            end
            // wait for in-flight positions
            ST_DRAIN: begin
                if (drain_last) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // --------------------
    // state, drain count and done
    // --------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= ST_IDLE;
            drain_cnt <= '0;
            done      <= 1'b0;
        end else begin
            state <= state_nxt;
            // counts only inside drain
            if (state == ST_DRAIN) begin
                drain_cnt <= drain_cnt + 1'b1;
            end else begin
                drain_cnt <= '0;
            end
            // one cycle after the last beat
            done <= (state == ST_DRAIN) && drain_last;
        end
    end

    // counter controls
    // clear also latches the config on the start cycle
    assign cnt_clear = (state == ST_IDLE) && start;
    assign cnt_step  = (state == ST_PREFILL) || (state == ST_STREAM);
    assign prefill   = (state == ST_PREFILL);

    // falls together with done
    assign busy = (state != ST_IDLE);

endmodule
